//--- files.f
+incdir+verilog
verilog/rvga_types.sv
verilog/rvga_alu.sv
verilog/rvga_bru.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/forward_unit.sv
verilog/rvga_backend.sv
verif/rvga_backend_props.sv
verif/rvga_backend_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the back-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rvga_backend_tb \
  -f files.f \
  --Mdir obj_dir -o rvga_backend_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/rvga_backend_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

//--- verif/rvga_backend_props.sv
`timescale 1ns/10ps
`include "rvga_defs.svh"

module rvga_backend_props
  (input logic                     clk_i
   , input logic                   rst_n_i
   , input logic                   cyc_i
   , input logic                   stb_i
   , input logic                   we_i
   , input logic [`RVGA_XLEN-1:0]  adr_i
   , input logic [`RVGA_XLEN-1:0]  dat_i
   , input logic [`RVGA_SELW-1:0]  sel_i
   , input logic                   ack_i
   , input logic                   stall_i
   , input logic                   rd_w_v_i
   );

  // --------------------------------------------------
  // Wishbone master rules
  // --------------------------------------------------
  cyc_has_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cyc_i |-> stb_i)
    else $error("Wishbone cycle raised without strobe");

  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cyc_i && !ack_i) |=> (cyc_i && stb_i && $stable(adr_i) && $stable(dat_i)
                           && $stable(sel_i) && $stable(we_i)))
    else $error("Wishbone request changed before ack");

  // Cycle ends right after ack
  cyc_drops: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cyc_i && ack_i) |=> !cyc_i)
    else $error("Wishbone cycle still open after ack");

  // --------------------------------------------------
  // Stall and reset
  // --------------------------------------------------
  stall_tracks_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_i == cyc_i)
    else $error("Stall does not follow the open bus cycle");

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> !rd_w_v_i)
    else $error("Register write strobe seen during reset");

endmodule : rvga_backend_props

bind rvga_backend rvga_backend_props props
  (.clk_i    (clk_i)
   ,.rst_n_i (rst_n_i)
   ,.cyc_i   (wb_cyc_o)
   ,.stb_i   (wb_stb_o)
   ,.we_i    (wb_we_o)
   ,.adr_i   (wb_adr_o)
   ,.dat_i   (wb_dat_o)
   ,.sel_i   (wb_sel_o)
   ,.ack_i   (wb_ack_i)
   ,.stall_i (stall_o)
   ,.rd_w_v_i(rd_w_v_o)
   );

//--- verif/rvga_backend_tb.sv
`timescale 1ns/10ps
`include "rvga_defs.svh"

module rvga_backend_tb;

  import rvga_types::*;

  localparam int NUM_INSTR   = 300;
  localparam int CYCLE_LIMIT = 4 * NUM_INSTR * 5;

  typedef struct packed {
    rvga_reg  rd;
    rvga_word data;
  } wr_exp_t;

  logic                   clk_i;
  logic                   rst_n_i;
  rvga_cword              cword_i;
  rvga_word               imm_data_i;
  rvga_word               rs1_data_i;
  rvga_word               rs2_data_i;
  logic                   wb_cyc_o;
  logic                   wb_stb_o;
  logic                   wb_we_o;
  logic [`RVGA_XLEN-1:0]  wb_adr_o;
  logic [`RVGA_XLEN-1:0]  wb_dat_o;
  logic [`RVGA_SELW-1:0]  wb_sel_o;
  logic [`RVGA_XLEN-1:0]  wb_dat_i;
  logic                   wb_ack_i;
  logic                   stall_o;
  logic                   br_v_o;
  logic                   bru_result_o;
  logic                   rd_w_v_o;
  rvga_reg                rd_addr_o;
  rvga_word               rd_data_o;

  rvga_word  arch_regs[8];
  rvga_word  model_regs[8];
  rvga_word  dmem[256];
  rvga_word  model_mem[256];
  wr_exp_t   wr_q[$];
  logic      br_q[$];
  int        issued;
  int        cycles;
  int        drain;
  int        ack_wait;
  logic      bus_wait;
  logic      load_gap;

  rvga_backend rvga_backend_i (.*);

  always #20 clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      fail_run("Timeout: pipeline did not drain within the cycle limit");
    end
  end

  // --------------------------------------------------
  // Reference rules
  // --------------------------------------------------
  function automatic rvga_word alu_ref(input logic [2:0] f3, input logic alt,
                                       input rvga_word a, input rvga_word b);
    case (f3)
      3'd0: alu_ref = alt ? a - b : a + b;
      3'd1: alu_ref = a << b[4:0];
      3'd2: alu_ref = {31'b0, $signed(a) < $signed(b)};
      3'd3: alu_ref = {31'b0, a < b};
      3'd4: alu_ref = a ^ b;
      3'd5: alu_ref = alt ? rvga_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input rvga_word a,
                                      input rvga_word b);
    case (f3)
      3'd0: branch_ref = (a == b);
      3'd1: branch_ref = (a != b);
      3'd4: branch_ref = ($signed(a) < $signed(b));
      3'd5: branch_ref = ($signed(a) >= $signed(b));
      3'd6: branch_ref = (a < b);
      default: branch_ref = (a >= b);
    endcase
  endfunction

  function automatic rvga_word load_ref(input logic [2:0] f3, input rvga_word w,
                                        input logic [1:0] off);
    logic [7:0]  by;
    logic [15:0] hf;
    by = w[8*off +: 8];
    hf = w[8*off +: 16];
    case (f3)
      3'd0: load_ref = {{24{by[7]}}, by};
      3'd4: load_ref = {24'b0, by};
      3'd1: load_ref = {{16{hf[15]}}, hf};
      3'd5: load_ref = {16'b0, hf};
      default: load_ref = w;
    endcase
  endfunction

  // --------------------------------------------------
  // Decode side
  // --------------------------------------------------
  task automatic build_instr();
    rvga_cword   cw;
    rvga_word    a;
    rvga_word    b;
    rvga_word    imm;
    rvga_word    res;
    logic [7:0]  idx;
    logic [1:0]  off;
    logic [2:0]  f3;
    logic        alt;
    int          kind;
    cw       = '0;
    cw.valid = 1'b1;
    cw.pc    = rvga_word'(issued * 4);
    cw.rs1   = 5'($urandom % 8);
    cw.rs2   = 5'($urandom % 8);
    cw.rd    = 5'($urandom % 8);
    imm      = rvga_word'(signed'(12'($urandom)));
    kind     = (issued < 8) ? 8 : int'($urandom % 8);
    f3       = 3'($urandom % 8);
    if (kind == 8) begin
      // Seed x0..x7 with addi from x0
      cw.rs1 = '0;
      cw.rd  = 5'(issued);
      f3     = 3'd0;
    end
    a = model_regs[cw.rs1[2:0]];
    b = model_regs[cw.rs2[2:0]];
    // Small window so loads often hit stored words
    idx = 8'($urandom % 16);
    off = 2'($urandom);
    if (kind == 4) begin
      cw.br_v = 1'b1;
      if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd4;
      br_q.push_back(branch_ref(f3, a, b));
    end else if (kind == 5 || kind == 6) begin
      cw.rs1 = '0;
      cw.imm_v = 1'b1;
      if (kind == 5) f3 = 3'($urandom % 3);
      else if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
      if (f3[1]) off = 2'b00;
      else if (f3[0]) off[0] = 1'b0;
      imm = {22'b0, idx, off};
      if (kind == 5) begin
        cw.dmem_w_v = 1'b1;
        case (f3)
          3'd0: model_mem[idx][8*off +: 8] = b[7:0];
          3'd1: model_mem[idx][8*off +: 16] = b[15:0];
          default: model_mem[idx] = b;
        endcase
      end else begin
        cw.dmem_r_v = 1'b1;
        cw.rd_w_v   = 1'b1;
        res = load_ref(f3, model_mem[idx], off);
        wr_q.push_back({cw.rd, res});
        if (cw.rd != 0) model_regs[cw.rd[2:0]] = res;
        load_gap = 1'b1;
      end
    end else begin
      cw.rd_w_v = 1'b1;
      cw.imm_v  = (kind == 8) ? 1'b1 : 1'($urandom % 2);
      if ((f3 == 3'd0 && !cw.imm_v) || f3 == 3'd5) begin
        if ($urandom % 2 == 1) cw.funct7 = 7'h20;
      end
      if (cw.imm_v && (f3 == 3'd1 || f3 == 3'd5)) begin
        imm = {20'b0, cw.funct7[5], 6'b0, 5'($urandom)};
      end
      alt = cw.funct7[5];
      res = alu_ref(f3, alt, a, cw.imm_v ? imm : b);
      wr_q.push_back({cw.rd, res});
      if (cw.rd != 0) model_regs[cw.rd[2:0]] = res;
    end
    cw.funct3  = rvga_funct3_e'(f3);
    cword_i    = cw;
    imm_data_i = imm;
    rs1_data_i = arch_regs[cw.rs1[2:0]];
    rs2_data_i = arch_regs[cw.rs2[2:0]];
    issued++;
  endtask

  task automatic drive_next();
    if (!stall_o) begin
      if (issued < NUM_INSTR && !load_gap) begin
        build_instr();
      end else begin
        // Bubble with valid low
        cword_i    = '0;
        imm_data_i = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        load_gap   = 1'b0;
      end
    end
  endtask

  // --------------------------------------------------
  // Data memory slave
  // --------------------------------------------------
  task automatic service_bus();
    logic [7:0] idx;
    idx = wb_adr_o[9:2];
    if (wb_ack_i) begin
      wb_ack_i = 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (!bus_wait) begin
        ack_wait = int'($urandom % 4);
        bus_wait = 1'b1;
      end
      if (ack_wait == 0) begin
        if (wb_we_o) begin
          for (int i = 0; i < `RVGA_SELW; i++) begin
            if (wb_sel_o[i]) dmem[idx][8*i +: 8] = wb_dat_o[8*i +: 8];
          end
        end else begin
          wb_dat_i = dmem[idx];
        end
        wb_ack_i = 1'b1;
        bus_wait = 1'b0;
      end else begin
        ack_wait--;
      end
    end
  endtask

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic check_outputs();
    wr_exp_t exp_wr;
    logic    exp_br;
    if (rd_w_v_o) begin
      if (wr_q.size() == 0) fail_run("Register write seen with no write pending");
      exp_wr = wr_q.pop_front();
      assert (rd_addr_o == exp_wr.rd)
        else fail_run($sformatf("Mismatch rd_addr_o: got %02h expected %02h",
                                rd_addr_o, exp_wr.rd));
      assert (rd_data_o == exp_wr.data)
        else fail_run($sformatf("Mismatch rd_data_o: got %08h expected %08h",
                                rd_data_o, exp_wr.data));
      if (rd_addr_o != 0) arch_regs[rd_addr_o[2:0]] = rd_data_o;
    end
    if (br_v_o && !stall_o) begin
      if (br_q.size() == 0) fail_run("Branch seen in execute with none pending");
      exp_br = br_q.pop_front();
      assert (bru_result_o == exp_br)
        else fail_run($sformatf("Mismatch bru_result_o: got %h expected %h",
                                bru_result_o, exp_br));
    end
  endtask

  initial begin
    void'($urandom(32'h0e4a_50f5));
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    cword_i     = '0;
    imm_data_i  = '0;
    rs1_data_i  = '0;
    rs2_data_i  = '0;
    wb_dat_i    = '0;
    wb_ack_i    = 1'b0;
    issued      = 0;
    cycles      = 0;
    drain       = 0;
    ack_wait    = 0;
    bus_wait    = 1'b0;
    load_gap    = 1'b0;
    for (int i = 0; i < 8; i++) begin
      arch_regs[i]  = '0;
      model_regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      dmem[i]      = (i * 32'h9e37_79b1) ^ {24'h5a_c3_00, 8'(i)};
      model_mem[i] = dmem[i];
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    while (!(drain >= 8 && wr_q.size() == 0 && br_q.size() == 0)) begin
      @(negedge clk_i);
      service_bus();
      check_outputs();
      drive_next();
      if (issued == NUM_INSTR && !wb_cyc_o) drain++;
      else drain = 0;
    end
    $display("test passed");
    $finish;
  end

endmodule : rvga_backend_tb

//--- verilog/execute_stage.sv
`timescale 1ns/10ps
`include "rvga_defs.svh"

module execute_stage
  (input logic                      clk_i
   , input logic                    rst_n_i
   , input logic                    stall_i
   , input rvga_types::rvga_cword   cword_i
   , input rvga_types::rvga_word    imm_data_i
   , input rvga_types::rvga_word    rs1_data_i
   , input rvga_types::rvga_word    rs2_data_i
   , input logic [`RVGA_FWDW-1:0]   fwd_rs1_sel_i
   , input logic [`RVGA_FWDW-1:0]   fwd_rs2_sel_i
   , input rvga_types::rvga_word    memory_rd_data_i
   , input rvga_types::rvga_word    writeback_rd_data_i
   , output rvga_types::rvga_cword  cword_o
   , output rvga_types::rvga_dword  dword_o
   , output logic                   br_v_o
   , output logic                   bru_result_o
   );

  import rvga_types::*;

  rvga_cword cword_r;
  rvga_word  imm_r;
  rvga_word  rs1_r;
  rvga_word  rs2_r;
  rvga_word  rs1_fwd;
  rvga_word  rs2_fwd;
  rvga_word  alu_a;
  rvga_word  alu_b;
  rvga_word  alu_result;
  logic      alu_alt;
  logic      addr_calc_v;

  function automatic rvga_word fwd_pick(input logic [`RVGA_FWDW-1:0] sel,
                                        input rvga_word rf_data);
    case (sel)
      `RVGA_FWD_MEM: fwd_pick = memory_rd_data_i;
      `RVGA_FWD_WB:  fwd_pick = writeback_rd_data_i;
      default:       fwd_pick = rf_data;
    endcase
  endfunction

  // --------------------------------------------------
  // Pipeline register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cword_r.valid <= 1'b0;
    end else if (!stall_i) begin
      cword_r <= cword_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      imm_r <= imm_data_i;
      rs1_r <= rs1_data_i;
      rs2_r <= rs2_data_i;
    end
  end

  // --------------------------------------------------
  // Operand selection
  // --------------------------------------------------
  always_comb begin
    rs1_fwd = fwd_pick(fwd_rs1_sel_i, rs1_r);
    rs2_fwd = fwd_pick(fwd_rs2_sel_i, rs2_r);
    alu_a   = cword_r.addpc_v ? cword_r.pc : rs1_fwd;
    alu_b   = cword_r.imm_v ? imm_r : rs2_fwd;
  end

  // Immediate adds never subtract, srai still does
  assign alu_alt = cword_r.funct7[5] & (~cword_r.imm_v | (cword_r.funct3 == F3_SR));
  assign addr_calc_v = cword_r.addpc_v | cword_r.dmem_r_v | cword_r.dmem_w_v;

  rvga_alu alu
    (.a_i           (alu_a)
     ,.b_i          (alu_b)
     ,.op_i         (cword_r.funct3)
     ,.alt_i        (alu_alt)
     ,.addr_calc_v_i(addr_calc_v)
     ,.result_o     (alu_result)
     );

  // Compares always use the register operands
  rvga_bru bru
    (.a_i     (rs1_fwd)
     ,.b_i    (rs2_fwd)
     ,.op_i   (cword_r.funct3)
     ,.taken_o(bru_result_o)
     );

  always_comb begin
    dword_o.imm_data   = imm_r;
    dword_o.rs1_data   = rs1_fwd;
    dword_o.rs2_data   = rs2_fwd;
    dword_o.alu_result = alu_result;
    dword_o.ld_result  = '0;
  end

  assign cword_o = cword_r;
  assign br_v_o  = cword_r.valid & cword_r.br_v;

endmodule : execute_stage

//--- verilog/forward_unit.sv
`timescale 1ns/10ps
`include "rvga_defs.svh"

module forward_unit
  (input rvga_types::rvga_cword     ex_cword_i
   , input rvga_types::rvga_cword   mem_cword_i
   , input rvga_types::rvga_cword   wb_cword_i
   , input logic                    mem_busy_i
   , output logic [`RVGA_FWDW-1:0]  fwd_rs1_sel_o
   , output logic [`RVGA_FWDW-1:0]  fwd_rs2_sel_o
   , output logic                   stall_o
   );

  import rvga_types::*;

  // x0 is never a bypass source
  function automatic logic writes_src(input rvga_cword cw, input rvga_reg src);
    writes_src = cw.valid & cw.rd_w_v & (cw.rd == src) & (src != '0);
  endfunction

  // Nearest producer wins
  function automatic logic [`RVGA_FWDW-1:0] pick_src(input rvga_reg src);
    if (writes_src(mem_cword_i, src)) begin
      pick_src = `RVGA_FWD_MEM;
    end else if (writes_src(wb_cword_i, src)) begin
      pick_src = `RVGA_FWD_WB;
    end else begin
      pick_src = `RVGA_FWD_RF;
    end
  endfunction

  always_comb begin
    fwd_rs1_sel_o = pick_src(ex_cword_i.rs1);
    fwd_rs2_sel_o = pick_src(ex_cword_i.rs2);
  end

  // Whole pipe waits on the data bus
  assign stall_o = mem_busy_i;

endmodule : forward_unit

//--- verilog/memory_stage.sv
`timescale 1ns/10ps
`include "rvga_defs.svh"

module memory_stage
  (input logic                       clk_i
   , input logic                     rst_n_i
   , input logic                     stall_i
   , input rvga_types::rvga_cword    cword_i
   , input rvga_types::rvga_dword    dword_i
   , output logic                    wb_cyc_o
   , output logic                    wb_stb_o
   , output logic                    wb_we_o
   , output logic [`RVGA_XLEN-1:0]   wb_adr_o
   , output logic [`RVGA_XLEN-1:0]   wb_dat_o
   , output logic [`RVGA_SELW-1:0]   wb_sel_o
   , input logic [`RVGA_XLEN-1:0]    wb_dat_i
   , input logic                     wb_ack_i
   , output logic                    mem_busy_o
   , output rvga_types::rvga_cword   mem_cword_o
   , output rvga_types::rvga_word    memory_rd_data_o
   , output rvga_types::rvga_cword   wb_cword_o
   , output rvga_types::rvga_word    writeback_rd_data_o
   , output logic                    rd_w_v_o
   , output rvga_types::rvga_reg     rd_addr_o
   , output rvga_types::rvga_word    rd_data_o
   );

  import rvga_types::*;

  typedef enum logic {WB_IDLE, WB_DONE} wb_state_e;

  wb_state_e     state_r;
  rvga_cword     mem_cword_r;
  rvga_dword     mem_dword_r;
  rvga_cword     wb_cword_r;
  rvga_word      wb_data_r;
  logic          access_v;
  logic          ack_v;
  logic [1:0]    byte_off;
  rvga_lane_word st_src;
  rvga_lane_word st_lane;
  rvga_lane_word ld_lane;
  logic [7:0]    ld_byte;
  logic [15:0]   ld_half;
  rvga_word      ld_ext;

  // --------------------------------------------------
  // Memory register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_cword_r.valid <= 1'b0;
    end else if (!stall_i) begin
      mem_cword_r <= cword_i;
    end
  end

  // Read data lands in ld_result on the ack cycle
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      mem_dword_r <= dword_i;
    end else if (ack_v && !mem_cword_r.dmem_w_v) begin
      mem_dword_r.ld_result <= wb_dat_i;
    end
  end

  // --------------------------------------------------
  // Wishbone sequencer
  // --------------------------------------------------
  assign access_v   = mem_cword_r.valid & (mem_cword_r.dmem_r_v | mem_cword_r.dmem_w_v);
  assign wb_cyc_o   = access_v & (state_r == WB_IDLE);
  assign wb_stb_o   = wb_cyc_o;
  assign wb_we_o    = mem_cword_r.dmem_w_v;
  assign ack_v      = wb_cyc_o & wb_ack_i;
  assign mem_busy_o = wb_cyc_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= WB_IDLE;
    end else begin
      case (state_r)
        WB_IDLE: if (ack_v) state_r <= WB_DONE;
        default: if (!stall_i) state_r <= WB_IDLE;
      endcase
    end
  end

  assign byte_off = mem_dword_r.alu_result[1:0];
  assign wb_adr_o = {mem_dword_r.alu_result[`RVGA_XLEN-1:2], 2'b00};
  assign wb_dat_o = st_lane.word;

  always_comb begin
    case (mem_cword_r.funct3)
      F3_SZ_B, F3_SZ_BU: wb_sel_o = `RVGA_SELW'(1) << byte_off;
      F3_SZ_H, F3_SZ_HU: wb_sel_o = byte_off[1] ? 4'b1100 : 4'b0011;
      F3_SZ_W:           wb_sel_o = '1;
      default:           wb_sel_o = '0;
    endcase
  end

  // Store data copied onto every lane
  always_comb begin
    st_src.word = mem_dword_r.rs2_data;
    for (int i = 0; i < `RVGA_SELW; i++) begin
      case (mem_cword_r.funct3)
        F3_SZ_B, F3_SZ_BU: st_lane.bytes[i] = st_src.bytes[0];
        F3_SZ_H, F3_SZ_HU: st_lane.bytes[i] = st_src.bytes[i % 2];
        default:           st_lane.bytes[i] = st_src.bytes[i];
      endcase
    end
  end

  // Lane pick and extension
  always_comb begin
    ld_lane.word = mem_dword_r.ld_result;
    ld_byte      = ld_lane.bytes[byte_off];
    ld_half      = {ld_lane.bytes[{byte_off[1], 1'b1}], ld_lane.bytes[{byte_off[1], 1'b0}]};
    case (mem_cword_r.funct3)
      F3_SZ_B:  ld_ext = {{24{ld_byte[7]}}, ld_byte};
      F3_SZ_BU: ld_ext = {24'b0, ld_byte};
      F3_SZ_H:  ld_ext = {{16{ld_half[15]}}, ld_half};
      F3_SZ_HU: ld_ext = {16'b0, ld_half};
      default:  ld_ext = ld_lane.word;
    endcase
  end

  // --------------------------------------------------
  // Writeback register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_cword_r.valid <= 1'b0;
    end else if (!stall_i) begin
      wb_cword_r <= mem_cword_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      wb_data_r <= mem_cword_r.dmem_r_v ? ld_ext : mem_dword_r.alu_result;
    end
  end

  assign mem_cword_o         = mem_cword_r;
  assign memory_rd_data_o    = mem_dword_r.alu_result;
  assign wb_cword_o          = wb_cword_r;
  assign writeback_rd_data_o = wb_data_r;
  // Held entry is written once, when the stall drops
  assign rd_w_v_o            = wb_cword_r.valid & wb_cword_r.rd_w_v & ~stall_i;
  assign rd_addr_o           = wb_cword_r.rd;
  assign rd_data_o           = wb_data_r;

endmodule : memory_stage

//--- verilog/rvga_alu.sv
`timescale 1ns/10ps

module rvga_alu
  (input rvga_types::rvga_word      a_i
   , input rvga_types::rvga_word    b_i
   , input rvga_types::rvga_funct3_e op_i
   , input logic                    alt_i
   , input logic                    addr_calc_v_i
   , output rvga_types::rvga_word   result_o
   );

  import rvga_types::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    if (addr_calc_v_i) begin
      // Loads, stores and pc-relative targets
      result_o = a_i + b_i;
    end else begin
      case (op_i)
        F3_ADD: begin
          result_o = alt_i ? a_i - b_i : a_i + b_i;
        end
        F3_SLL: begin
          result_o = a_i << shamt;
        end
        F3_SLT: begin
          result_o = rvga_word'($signed(a_i) < $signed(b_i));
        end
        F3_SLTU: begin
          result_o = rvga_word'(a_i < b_i);
        end
        F3_XOR: begin
          result_o = a_i ^ b_i;
        end
        F3_SR: begin
          result_o = alt_i ? rvga_word'($signed(a_i) >>> shamt) : a_i >> shamt;
        end
        F3_OR: begin
          result_o = a_i | b_i;
        end
        F3_AND: begin
          result_o = a_i & b_i;
        end
        default: begin
          result_o = '0;
        end
      endcase
    end
  end

endmodule : rvga_alu

//--- verilog/rvga_backend.sv
`timescale 1ns/10ps
`include "rvga_defs.svh"

module rvga_backend
  (input logic                       clk_i
   , input logic                     rst_n_i
   , input rvga_types::rvga_cword    cword_i
   , input rvga_types::rvga_word     imm_data_i
   , input rvga_types::rvga_word     rs1_data_i
   , input rvga_types::rvga_word     rs2_data_i
   , output logic                    wb_cyc_o
   , output logic                    wb_stb_o
   , output logic                    wb_we_o
   , output logic [`RVGA_XLEN-1:0]   wb_adr_o
   , output logic [`RVGA_XLEN-1:0]   wb_dat_o
   , output logic [`RVGA_SELW-1:0]   wb_sel_o
   , input logic [`RVGA_XLEN-1:0]    wb_dat_i
   , input logic                     wb_ack_i
   , output logic                    stall_o
   , output logic                    br_v_o
   , output logic                    bru_result_o
   , output logic                    rd_w_v_o
   , output rvga_types::rvga_reg     rd_addr_o
   , output rvga_types::rvga_word    rd_data_o
   );

  import rvga_types::*;

  rvga_cword              ex_cword;
  rvga_dword              ex_dword;
  rvga_cword              mem_cword;
  rvga_cword              wb_cword;
  rvga_word               memory_rd_data;
  rvga_word               writeback_rd_data;
  logic [`RVGA_FWDW-1:0]  fwd_rs1_sel;
  logic [`RVGA_FWDW-1:0]  fwd_rs2_sel;
  logic                   mem_busy;

  execute_stage execute
    (.clk_i              (clk_i)
     ,.rst_n_i           (rst_n_i)
     ,.stall_i           (stall_o)
     ,.cword_i           (cword_i)
     ,.imm_data_i        (imm_data_i)
     ,.rs1_data_i        (rs1_data_i)
     ,.rs2_data_i        (rs2_data_i)
     ,.fwd_rs1_sel_i     (fwd_rs1_sel)
     ,.fwd_rs2_sel_i     (fwd_rs2_sel)
     ,.memory_rd_data_i  (memory_rd_data)
     ,.writeback_rd_data_i(writeback_rd_data)
     ,.cword_o           (ex_cword)
     ,.dword_o           (ex_dword)
     ,.br_v_o            (br_v_o)
     ,.bru_result_o      (bru_result_o)
     );

  memory_stage memory
    (.clk_i              (clk_i)
     ,.rst_n_i           (rst_n_i)
     ,.stall_i           (stall_o)
     ,.cword_i           (ex_cword)
     ,.dword_i           (ex_dword)
     ,.wb_cyc_o          (wb_cyc_o)
     ,.wb_stb_o          (wb_stb_o)
     ,.wb_we_o           (wb_we_o)
     ,.wb_adr_o          (wb_adr_o)
     ,.wb_dat_o          (wb_dat_o)
     ,.wb_sel_o          (wb_sel_o)
     ,.wb_dat_i          (wb_dat_i)
     ,.wb_ack_i          (wb_ack_i)
     ,.mem_busy_o        (mem_busy)
     ,.mem_cword_o       (mem_cword)
     ,.memory_rd_data_o  (memory_rd_data)
     ,.wb_cword_o        (wb_cword)
     ,.writeback_rd_data_o(writeback_rd_data)
     ,.rd_w_v_o          (rd_w_v_o)
     ,.rd_addr_o         (rd_addr_o)
     ,.rd_data_o         (rd_data_o)
     );

  forward_unit forward
    (.ex_cword_i   (ex_cword)
     ,.mem_cword_i (mem_cword)
     ,.wb_cword_i  (wb_cword)
     ,.mem_busy_i  (mem_busy)
     ,.fwd_rs1_sel_o(fwd_rs1_sel)
     ,.fwd_rs2_sel_o(fwd_rs2_sel)
     ,.stall_o     (stall_o)
     );

endmodule : rvga_backend

//--- verilog/rvga_bru.sv
`timescale 1ns/10ps

module rvga_bru
  (input rvga_types::rvga_word       a_i
   , input rvga_types::rvga_word     b_i
   , input rvga_types::rvga_funct3_e op_i
   , output logic                    taken_o
   );

  import rvga_types::*;

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (a_i == b_i);
  assign lt_s = ($signed(a_i) < $signed(b_i));
  assign lt_u = (a_i < b_i);

  always_comb begin
    case (op_i)
      F3_BEQ:  taken_o = eq;
      F3_BNE:  taken_o = ~eq;
      F3_BLT:  taken_o = lt_s;
      F3_BGE:  taken_o = ~lt_s;
      F3_BLTU: taken_o = lt_u;
      F3_BGEU: taken_o = ~lt_u;
      // Codes 2 and 3 are not branches
      default: taken_o = 1'b0;
    endcase
  end

endmodule : rvga_bru

//--- verilog/rvga_defs.svh
`ifndef RVGA_DEFS_SVH
`define RVGA_DEFS_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
`define RVGA_XLEN 32
`define RVGA_REGW 5

// Wishbone byte lanes
`define RVGA_SELW 4

// --------------------------------------------------
// Bypass select encodings
// --------------------------------------------------
`define RVGA_FWDW    2
`define RVGA_FWD_RF  2'b00
`define RVGA_FWD_WB  2'b01
`define RVGA_FWD_MEM 2'b10

`endif

//--- verilog/rvga_types.sv
`include "rvga_defs.svh"

package rvga_types;

  typedef logic [`RVGA_XLEN-1:0] rvga_word;
  typedef logic [`RVGA_REGW-1:0] rvga_reg;

  // ALU funct3 codes
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } rvga_funct3_e;

  // Branch compares reuse the same field
  localparam rvga_funct3_e F3_BEQ  = rvga_funct3_e'(3'b000);
  localparam rvga_funct3_e F3_BNE  = rvga_funct3_e'(3'b001);
  localparam rvga_funct3_e F3_BLT  = rvga_funct3_e'(3'b100);
  localparam rvga_funct3_e F3_BGE  = rvga_funct3_e'(3'b101);
  localparam rvga_funct3_e F3_BLTU = rvga_funct3_e'(3'b110);
  localparam rvga_funct3_e F3_BGEU = rvga_funct3_e'(3'b111);

  // Load and store sizes
  localparam rvga_funct3_e F3_SZ_B  = rvga_funct3_e'(3'b000);
  localparam rvga_funct3_e F3_SZ_H  = rvga_funct3_e'(3'b001);
  localparam rvga_funct3_e F3_SZ_W  = rvga_funct3_e'(3'b010);
  localparam rvga_funct3_e F3_SZ_BU = rvga_funct3_e'(3'b100);
  localparam rvga_funct3_e F3_SZ_HU = rvga_funct3_e'(3'b101);

  typedef struct packed {
    rvga_word     pc;
    rvga_reg      rs1;
    rvga_reg      rs2;
    rvga_reg      rd;
    rvga_funct3_e funct3;
    logic [6:0]   funct7;
    logic         imm_v;
    logic         addpc_v;
    logic         dmem_r_v;
    logic         dmem_w_v;
    logic         br_v;
    logic         rd_w_v;
    logic         valid;
  } rvga_cword;

  typedef struct packed {
    rvga_word imm_data;
    rvga_word rs1_data;
    rvga_word rs2_data;
    rvga_word alu_result;
    rvga_word ld_result;
  } rvga_dword;

  // Bus word as a whole or by byte lane
  typedef union packed {
    rvga_word                        word;
    logic [`RVGA_SELW-1:0][7:0]      bytes;
  } rvga_lane_word;

endpackage
